// File: mmio_consts.svh
`ifndef MMIO_CONSTS_SVH
`define MMIO_CONSTS_SVH

// serial transmitter window
`define MMIO_UART_TX_BASE 32'hF000_0000
`define MMIO_UART_TX_END 32'hF000_0003

// serial receiver window
`define MMIO_UART_RX_BASE 32'hF000_0010
`define MMIO_UART_RX_END 32'hF000_0013

// mtimecmp and mtime words, four registers
`define MMIO_TIMER_BASE 32'hF000_0100
`define MMIO_TIMER_END 32'hF000_010F

// default region depth in 32-bit words
`define MMIO_RAM_WORDS 1024

// clocks per serial bit, kept short for simulation
`define MMIO_CLKS_PER_BIT 8

// all ones so no compare match right after reset
`define MMIO_MTIMECMP_RESET 64'hFFFF_FFFF_FFFF_FFFF

`endif

// File: bus_pkg.sv
package bus_pkg;

    // byte address on the command port
    typedef logic [31:0] addr_t;

    // read and write data word
    typedef logic [31:0] data_t;

    // decoded target of a command, ram is the default
    typedef enum logic [1:0] {
        region_ram     = 2'd0,
        region_uart_tx = 2'd1,
        region_uart_rx = 2'd2,
        region_timer   = 2'd3
    } region_t;

endpackage

// File: periph_pkg.sv
package periph_pkg;

    // one 8N1 character
    typedef logic [7:0] uart_byte_t;

    // clocks elapsed within one bit time
    typedef logic [15:0] bit_count_t;

    // machine time and compare values
    typedef logic [63:0] mtime_t;

endpackage

// File: mmio_uart_tx.sv
`timescale 1ns/100ps
`include "mmio_consts.svh"

module mmio_uart_tx (
    input  logic           clk,
    input  logic           rst,
    input  logic           cmd_start,
    input  logic           cmd_write,
    input  bus_pkg::addr_t addr,
    input  bus_pkg::data_t wdata,
    output logic           cmd_ready,
    output bus_pkg::data_t rdata,
    output logic           rdata_valid,
    output logic           uart_tx
);

    localparam periph_pkg::bit_count_t last_clk = `MMIO_CLKS_PER_BIT - 1;

    periph_pkg::uart_byte_t tx_byte;
    periph_pkg::bit_count_t clk_cnt;
    logic [9:0]             tx_shift;
    logic [3:0]             bits_left;
    logic                   busy;

    assign tx_byte   = wdata[7:0];
    assign cmd_ready = !busy;
    // line idles high because the shifter fills with ones
    assign uart_tx   = tx_shift[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy        <= 1'b0;
            tx_shift    <= '1;
            bits_left   <= '0;
            clk_cnt     <= '0;
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= cmd_start && !cmd_write;
            if (busy) begin
                if (clk_cnt == last_clk) begin
                    clk_cnt   <= '0;
                    tx_shift  <= {1'b1, tx_shift[9:1]};
                    bits_left <= bits_left - 4'd1;
                    // stop bit just finished
                    if (bits_left == 4'd1) begin
                        busy <= 1'b0;
                    end
                end else begin
                    clk_cnt <= clk_cnt + 1'b1;
                end
            end else if (cmd_start && cmd_write) begin
                // stop, data lsb first, start
                tx_shift  <= {1'b1, tx_byte, 1'b0};
                bits_left <= 4'd10;
                clk_cnt   <= '0;
                busy      <= 1'b1;
            end
        end
    end

    // status word, busy in bit 0; the window is a single word
    always_ff @(posedge clk) begin
        if (cmd_start && !cmd_write) begin
            rdata <= {31'b0, busy && (addr[31:2] == 30'd0)};
        end
    end

endmodule

// File: mmio_uart_rx.sv
`timescale 1ns/100ps
`include "mmio_consts.svh"

module mmio_uart_rx (
    input  logic           clk,
    input  logic           rst,
    input  logic           cmd_start,
    input  logic           cmd_write,
    input  bus_pkg::addr_t addr,
    input  bus_pkg::data_t wdata,
    input  logic           uart_rx,
    output logic           cmd_ready,
    output bus_pkg::data_t rdata,
    output logic           rdata_valid
);

    localparam periph_pkg::bit_count_t last_clk = `MMIO_CLKS_PER_BIT - 1;
    localparam periph_pkg::bit_count_t half_clk = `MMIO_CLKS_PER_BIT / 2 - 1;

    typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} rx_state_t;

    rx_state_t              state;
    periph_pkg::bit_count_t clk_cnt;
    periph_pkg::uart_byte_t rx_shift;
    periph_pkg::uart_byte_t hold_byte;
    logic [2:0]             bit_idx;
    logic                   rx_meta;
    logic                   rx_sync;
    logic                   hold_valid;
    logic                   rd_req;
    logic                   byte_done;

    assign cmd_ready = 1'b1;
    // writes land here too but change nothing
    assign rd_req    = cmd_start && !cmd_write && (addr[31:2] == 30'd0);
    assign byte_done = (state == st_stop) && (clk_cnt == last_clk) && rx_sync;

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta     <= 1'b1;
            rx_sync     <= 1'b1;
            state       <= st_idle;
            clk_cnt     <= '0;
            bit_idx     <= '0;
            hold_valid  <= 1'b0;
            rdata_valid <= 1'b0;
        end else begin
            rx_meta     <= uart_rx;
            rx_sync     <= rx_meta;
            rdata_valid <= cmd_start && !cmd_write;
            clk_cnt     <= clk_cnt + 1'b1;
            case (state)
                st_idle: begin
                    clk_cnt <= '0;
                    if (!rx_sync) state <= st_start;
                end
                st_start: if (clk_cnt == half_clk) begin
                    // mid start bit, a glitch goes back to idle
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    state   <= rx_sync ? st_idle : st_data;
                end
                st_data: if (clk_cnt == last_clk) begin
                    clk_cnt <= '0;
                    bit_idx <= bit_idx + 3'd1;
                    if (bit_idx == 3'd7) state <= st_stop;
                end
                default: if (clk_cnt == last_clk) state <= st_idle;
            endcase
            // new byte wins over a read in the same cycle
            if (byte_done) begin
                hold_valid <= 1'b1;
            end else if (rd_req) begin
                hold_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_data && clk_cnt == last_clk) rx_shift <= {rx_sync, rx_shift[7:1]};
        if (byte_done) hold_byte <= rx_shift;
        if (cmd_start && !cmd_write) rdata <= {23'b0, hold_valid, hold_byte};
    end

endmodule

// File: mmio_timer.sv
`timescale 1ns/100ps
`include "mmio_consts.svh"

module mmio_timer (
    input  logic               clk,
    input  logic               rst,
    input  logic               cmd_start,
    input  logic               cmd_write,
    input  bus_pkg::addr_t     addr,
    input  bus_pkg::data_t     wdata,
    input  periph_pkg::mtime_t mtime,
    output logic               cmd_ready,
    output bus_pkg::data_t     rdata,
    output logic               rdata_valid,
    output periph_pkg::mtime_t mtimecmp
);

    assign cmd_ready = 1'b1;

    // offsets 0 and 4 hold mtimecmp, 8 and 12 are read-only
    always_ff @(posedge clk) begin
        if (rst) begin
            mtimecmp    <= `MMIO_MTIMECMP_RESET;
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= cmd_start && !cmd_write;
            if (cmd_start && cmd_write) begin
                case (addr[3:2])
                    2'd0: mtimecmp[31:0] <= wdata;
                    2'd1: mtimecmp[63:32] <= wdata;
                    default: ;
                endcase
            end
        end
    end

    // mtime is captured on the start edge
    always_ff @(posedge clk) begin
        if (cmd_start && !cmd_write) begin
            case (addr[3:2])
                2'd0: rdata <= mtimecmp[31:0];
                2'd1: rdata <= mtimecmp[63:32];
                2'd2: rdata <= mtime[31:0];
                default: rdata <= mtime[63:32];
            endcase
        end
    end

endmodule

// File: ram_memory.sv
`timescale 1ns/100ps
`include "mmio_consts.svh"

module ram_memory #(
    parameter int words = `MMIO_RAM_WORDS
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           cmd_start,
    input  logic           cmd_write,
    input  bus_pkg::addr_t addr,
    input  bus_pkg::data_t wdata,
    output logic           cmd_ready,
    output bus_pkg::data_t rdata,
    output logic           rdata_valid
);

    localparam int aw = $clog2(words);

    bus_pkg::data_t mem [words];
    logic [aw-1:0]  idx;

    // word index, upper address bits alias
    assign idx       = addr[aw+1:2];
    assign cmd_ready = 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= cmd_start && !cmd_write;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_start && cmd_write) mem[idx] <= wdata;
        if (cmd_start && !cmd_write) rdata <= mem[idx];
    end

endmodule

// File: memory_map_ctrl.sv
`timescale 1ns/100ps
`include "mmio_consts.svh"

module memory_map_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                uart_rx,
    output logic                uart_tx,
    input  periph_pkg::mtime_t  mtime,
    output periph_pkg::mtime_t  mtimecmp,
    input  logic                cmd_start,
    input  logic                cmd_write,
    output logic                cmd_ready,
    input  bus_pkg::addr_t      addr,
    output bus_pkg::data_t      rdata,
    output logic                rdata_valid,
    input  bus_pkg::data_t      wdata
);

    bus_pkg::region_t region;

    logic           tx_start;
    logic           tx_write;
    logic           tx_ready;
    logic           tx_valid;
    bus_pkg::data_t tx_rdata;
    logic           rx_start;
    logic           rx_write;
    logic           rx_ready;
    logic           rx_valid;
    bus_pkg::data_t rx_rdata;
    logic           tmr_start;
    logic           tmr_write;
    logic           tmr_ready;
    logic           tmr_valid;
    bus_pkg::data_t tmr_rdata;
    logic           ram_start;
    logic           ram_write;
    logic           ram_ready;
    logic           ram_valid;
    bus_pkg::data_t ram_rdata;

    // address decode, anything outside the peripheral windows is ram
    always_comb begin
        region = bus_pkg::region_ram;
        if (addr >= `MMIO_UART_TX_BASE && addr <= `MMIO_UART_TX_END) begin
            region = bus_pkg::region_uart_tx;
        end else if (addr >= `MMIO_UART_RX_BASE && addr <= `MMIO_UART_RX_END) begin
            region = bus_pkg::region_uart_rx;
        end else if (addr >= `MMIO_TIMER_BASE && addr <= `MMIO_TIMER_END) begin
            region = bus_pkg::region_timer;
        end
    end

    // strobes reach the selected block only
    assign tx_start  = cmd_start && (region == bus_pkg::region_uart_tx);
    assign tx_write  = cmd_write && (region == bus_pkg::region_uart_tx);
    assign rx_start  = cmd_start && (region == bus_pkg::region_uart_rx);
    assign rx_write  = cmd_write && (region == bus_pkg::region_uart_rx);
    assign tmr_start = cmd_start && (region == bus_pkg::region_timer);
    assign tmr_write = cmd_write && (region == bus_pkg::region_timer);
    assign ram_start = cmd_start && (region == bus_pkg::region_ram);
    assign ram_write = cmd_write && (region == bus_pkg::region_ram);

    mmio_uart_tx mmio_uart_tx_inst (
        .clk(clk), .rst(rst), .cmd_start(tx_start), .cmd_write(tx_write),
        .addr(addr - `MMIO_UART_TX_BASE), .wdata(wdata), .cmd_ready(tx_ready),
        .rdata(tx_rdata), .rdata_valid(tx_valid), .uart_tx(uart_tx)
    );

    mmio_uart_rx mmio_uart_rx_inst (
        .clk(clk), .rst(rst), .cmd_start(rx_start), .cmd_write(rx_write),
        .addr(addr - `MMIO_UART_RX_BASE), .wdata(wdata), .uart_rx(uart_rx),
        .cmd_ready(rx_ready), .rdata(rx_rdata), .rdata_valid(rx_valid)
    );

    mmio_timer mmio_timer_inst (
        .clk(clk), .rst(rst), .cmd_start(tmr_start), .cmd_write(tmr_write),
        .addr(addr - `MMIO_TIMER_BASE), .wdata(wdata), .mtime(mtime),
        .cmd_ready(tmr_ready), .rdata(tmr_rdata), .rdata_valid(tmr_valid),
        .mtimecmp(mtimecmp)
    );

    // ram sees the full address, it wraps internally
    ram_memory ram_memory_inst (
        .clk(clk), .rst(rst), .cmd_start(ram_start), .cmd_write(ram_write),
        .addr(addr), .wdata(wdata), .cmd_ready(ram_ready),
        .rdata(ram_rdata), .rdata_valid(ram_valid)
    );

    // response from whichever block the address points at
    always_comb begin
        case (region)
            bus_pkg::region_uart_tx: {cmd_ready, rdata, rdata_valid} = {tx_ready, tx_rdata, tx_valid};
            bus_pkg::region_uart_rx: {cmd_ready, rdata, rdata_valid} = {rx_ready, rx_rdata, rx_valid};
            bus_pkg::region_timer: {cmd_ready, rdata, rdata_valid} = {tmr_ready, tmr_rdata, tmr_valid};
            default: {cmd_ready, rdata, rdata_valid} = {ram_ready, ram_rdata, ram_valid};
        endcase
    end

endmodule

// File: tb_memory_map_ctrl.sv
`timescale 1ns/100ps
`include "mmio_consts.svh"

module tb_memory_map_ctrl;

    localparam int timeout_cycles = 40 * `MMIO_CLKS_PER_BIT;
    localparam int clk_period = 10;

    logic clk, rst, uart_tx, rx_line, src_line, loop_en;
    logic cmd_start, cmd_write, cmd_ready, rdata_valid;
    periph_pkg::mtime_t mtime, mtimecmp, start_mtime;
    bus_pkg::addr_t addr;
    bus_pkg::data_t wdata, rdata;
    bus_pkg::data_t model [`MMIO_RAM_WORDS];
    string test_name;
    int errors, checks;

    // serial loopback, or a line driven by the testbench
    assign rx_line = loop_en ? uart_tx : src_line;

    memory_map_ctrl memory_map_ctrl_inst (
        .clk(clk), .rst(rst), .uart_rx(rx_line), .uart_tx(uart_tx),
        .mtime(mtime), .mtimecmp(mtimecmp), .cmd_start(cmd_start),
        .cmd_write(cmd_write), .cmd_ready(cmd_ready), .addr(addr),
        .rdata(rdata), .rdata_valid(rdata_valid), .wdata(wdata)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // free-running machine time
    always @(posedge clk) mtime <= #1 mtime + 64'd1;

    task automatic check_data(input bus_pkg::data_t expected, input bus_pkg::data_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", test_name, expected, actual);
        end
    endtask

    task automatic check_time(input periph_pkg::mtime_t expected,
                              input periph_pkg::mtime_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", test_name, expected, actual);
        end
    endtask

    task automatic check_latency(input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("** Error %s: expected latency %0d, actual %0d", test_name, expected, actual);
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!cmd_ready && n < timeout_cycles) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!cmd_ready) begin
            errors++;
            $display("%s: timed out waiting for cmd_ready to go high", test_name);
        end
    endtask

    task automatic bus_write(input bus_pkg::addr_t a, input bus_pkg::data_t d);
        addr = a;
        wdata = d;
        cmd_write = 1'b1;
        @(posedge clk);
        #1;
        wait_ready();
        cmd_start = 1'b1;
        @(posedge clk);
        #1;
        cmd_start = 1'b0;
    endtask

    // hold_off low issues the read without looking at cmd_ready
    task automatic bus_read(input bus_pkg::addr_t a, input bit hold_off,
                            output bus_pkg::data_t d);
        int lat;
        addr = a;
        cmd_write = 1'b0;
        if (hold_off) begin
            @(posedge clk);
            #1;
            wait_ready();
        end
        cmd_start = 1'b1;
        @(posedge clk);
        // value of mtime that the timer samples on this edge
        start_mtime = mtime;
        #1;
        cmd_start = 1'b0;
        lat = 1;
        while (!rdata_valid && lat < timeout_cycles) begin
            @(posedge clk);
            #1;
            lat++;
        end
        d = rdata;
        if (rdata_valid) begin
            check_latency(1, lat);
        end else begin
            errors++;
            $display("%s: timed out waiting for rdata_valid", test_name);
        end
    endtask

    // start bit, data lsb first, stop bit, then one idle bit
    task automatic send_serial(input periph_pkg::uart_byte_t b);
        logic [10:0] frame;
        frame = {2'b11, b, 1'b0};
        for (int i = 0; i < 11; i++) begin
            src_line = frame[i];
            repeat (`MMIO_CLKS_PER_BIT) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic test_ram();
        bus_pkg::addr_t addrs [32];
        bit used [`MMIO_RAM_WORDS];
        bus_pkg::data_t rd;
        int idx;
        test_name = "ram_round_trip";
        for (int i = 0; i < 32; i++) begin
            // stays below the peripheral space even one depth higher
            do begin
                addrs[i] = ($urandom % 32'h3BFF_FC00) << 2;
                idx = (addrs[i] >> 2) % `MMIO_RAM_WORDS;
            end while (used[idx]);
            used[idx] = 1'b1;
            model[idx] = $urandom;
            bus_write(addrs[i], model[idx]);
        end
        for (int i = 0; i < 32; i++) begin
            bus_read(addrs[i], 1'b1, rd);
            check_data(model[(addrs[i] >> 2) % `MMIO_RAM_WORDS], rd);
        end
        idx = (addrs[0] >> 2) % `MMIO_RAM_WORDS;
        model[idx] = ~model[idx];
        bus_write(addrs[0] + 4 * `MMIO_RAM_WORDS, model[idx]);
        bus_read(addrs[0], 1'b1, rd);
        check_data(model[idx], rd);
    endtask

    task automatic test_timer();
        periph_pkg::mtime_t cmp;
        bus_pkg::data_t lo, hi;
        test_name = "timer_registers";
        bus_read(`MMIO_TIMER_BASE, 1'b1, lo);
        bus_read(`MMIO_TIMER_BASE + 4, 1'b1, hi);
        check_time(`MMIO_MTIMECMP_RESET, {hi, lo});
        cmp = {$urandom, $urandom};
        bus_write(`MMIO_TIMER_BASE, cmp[31:0]);
        bus_write(`MMIO_TIMER_BASE + 4, cmp[63:32]);
        check_time(cmp, mtimecmp);
        bus_read(`MMIO_TIMER_BASE, 1'b1, lo);
        bus_read(`MMIO_TIMER_BASE + 4, 1'b1, hi);
        check_time(cmp, {hi, lo});
        bus_read(`MMIO_TIMER_BASE + 8, 1'b1, lo);
        check_data(start_mtime[31:0], lo);
        bus_read(`MMIO_TIMER_BASE + 12, 1'b1, hi);
        check_data(start_mtime[63:32], hi);
    endtask

    task automatic test_uart_loopback();
        periph_pkg::uart_byte_t b;
        bus_pkg::data_t rd;
        time t_start;
        test_name = "uart_loopback";
        loop_en = 1'b1;
        b = $urandom;
        bus_write(`MMIO_UART_TX_BASE, {24'h0, b});
        // one step past the start edge
        t_start = $time;
        checks++;
        if (cmd_ready) begin
            errors++;
            $display("%s: cmd_ready stayed high while the frame was sent", test_name);
        end
        bus_read(`MMIO_UART_TX_BASE, 1'b0, rd);
        check_data(32'd1, rd);
        wait_ready();
        // ready returns ten bit times after the start edge
        check_latency(10 * `MMIO_CLKS_PER_BIT, int'(($time - t_start) / clk_period));
        bus_read(`MMIO_UART_RX_BASE, 1'b1, rd);
        check_data({23'd0, 1'b1, b}, rd);
        bus_read(`MMIO_UART_RX_BASE, 1'b1, rd);
        check_data(32'd0, rd & 32'h100);
    endtask

    task automatic test_serial_rx();
        periph_pkg::uart_byte_t b1, b2;
        bus_pkg::data_t rd;
        test_name = "serial_receive";
        loop_en = 1'b0;
        for (int i = 0; i < 4; i++) begin
            b1 = $urandom;
            send_serial(b1);
            bus_read(`MMIO_UART_RX_BASE, 1'b1, rd);
            check_data({23'd0, 1'b1, b1}, rd);
        end
        // second byte overwrites an unread first one
        b1 = $urandom;
        b2 = $urandom;
        send_serial(b1);
        send_serial(b2);
        bus_read(`MMIO_UART_RX_BASE, 1'b1, rd);
        check_data({23'd0, 1'b1, b2}, rd);
        bus_read(`MMIO_UART_RX_BASE, 1'b1, rd);
        check_data(32'd0, rd & 32'h100);
        loop_en = 1'b1;
    endtask

    task automatic test_decode();
        bus_pkg::data_t a_val, b_val, c_val, rd;
        test_name = "decode_isolation";
        a_val = $urandom;
        b_val = $urandom;
        c_val = $urandom;
        bus_write(32'h0000_0010, a_val);
        bus_write(32'h0000_0100, b_val);
        bus_write(`MMIO_UART_RX_BASE, ~a_val);
        bus_write(`MMIO_TIMER_BASE, ~b_val);
        bus_read(32'h0000_0010, 1'b1, rd);
        check_data(a_val, rd);
        bus_read(32'h0000_0100, 1'b1, rd);
        check_data(b_val, rd);
        // first byte past the timer window is ram again
        bus_write(`MMIO_TIMER_END + 1, c_val);
        bus_read(`MMIO_TIMER_END + 1, 1'b1, rd);
        check_data(c_val, rd);
        bus_read(32'h0000_0110, 1'b1, rd);
        check_data(c_val, rd);
    endtask

    initial begin
        rst = 1'b1;
        cmd_start = 1'b0;
        cmd_write = 1'b0;
        addr = '0;
        wdata = '0;
        // upper word nonzero so both halves of mtime carry data
        mtime = 64'h0000_5a3c_0000_0000;
        src_line = 1'b1;
        loop_en = 1'b1;
        errors = 0;
        checks = 0;
        test_name = "reset";
        void'($urandom(32'hb643));
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        test_ram();
        test_timer();
        test_uart_loopback();
        test_serial_rx();
        test_decode();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+.
bus_pkg.sv
periph_pkg.sv
mmio_uart_tx.sv
mmio_uart_rx.sv
mmio_timer.sv
ram_memory.sv
memory_map_ctrl.sv
tb_memory_map_ctrl.sv

// File: Bender.yml
package:
  name: memory_map_ctrl

sources:
  - include_dirs:
      - .
    files:
      - bus_pkg.sv
      - periph_pkg.sv
      - mmio_uart_tx.sv
      - mmio_uart_rx.sv
      - mmio_timer.sv
      - ram_memory.sv
      - memory_map_ctrl.sv
      - target: simulation
        files:
          - tb_memory_map_ctrl.sv
